//--- verilog/lane_pkg.sv
package lane_pkg;

   localparam int WORD_W    = 32;  // Lane word
   localparam int IMM_W     = 5;
   localparam int SEW_W     = 2;
   localparam int OPMODE_W  = 3;
   localparam int OP2_SEL_W = 2;

   // Element width codes, 3 behaves as 32 bit
   localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
   localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
   localparam logic [SEW_W-1:0] SEW_32 = 2'd2;

   // ALU opcodes, 5 to 7 give zero
   localparam logic [OPMODE_W-1:0] OP_ADD = 3'd0;
   localparam logic [OPMODE_W-1:0] OP_SUB = 3'd1;
   localparam logic [OPMODE_W-1:0] OP_AND = 3'd2;
   localparam logic [OPMODE_W-1:0] OP_OR  = 3'd3;
   localparam logic [OPMODE_W-1:0] OP_XOR = 3'd4;

   // Operand 2 source, 3 is reserved and falls back to the vector
   localparam logic [OP2_SEL_W-1:0] OP2_VEC    = 2'd0;
   localparam logic [OP2_SEL_W-1:0] OP2_SCALAR = 2'd1;
   localparam logic [OP2_SEL_W-1:0] OP2_IMM    = 2'd2;

   // One lane word seen as word, halves or bytes
   typedef union packed {
      logic [WORD_W-1:0]   word;
      logic [1:0][15:0]    half;
      logic [3:0][7:0]     bytes;
   } lane_word_u;

   // Bits that belong to one element at the given SEW
   function automatic logic [WORD_W-1:0] sew_mask(input logic [SEW_W-1:0] sew);
      if (sew >= SEW_32)
         return {WORD_W{1'b1}};
      else if (sew == SEW_16)
         return {{(WORD_W-16){1'b0}}, 16'hffff};
      else
         return {{(WORD_W-8){1'b0}}, 8'hff};
   endfunction

endpackage

//--- verilog/operand_gather.sv
`timescale 1ns/1ps

module operand_gather
   import lane_pkg::*;
#(
   parameter int VLANE_NUM = 8
)
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          valid_i,
   input  logic [SEW_W-1:0]              sew_i,
   input  logic [OPMODE_W-1:0]           opmode_i,
   input  logic [OP2_SEL_W-1:0]          op2_sel_i,
   input  logic [WORD_W-1:0]             scalar_i,
   input  logic [IMM_W-1:0]              imm_i,
   input  lane_word_u [VLANE_NUM-1:0]    vs1_i,
   input  lane_word_u [VLANE_NUM-1:0]    vs2_i,
   output logic                          op_valid_o,
   output logic [SEW_W-1:0]              op_sew_o,
   output logic [OPMODE_W-1:0]           op_opmode_o,
   output lane_word_u [VLANE_NUM-1:0]    op_a_o,
   output lane_word_u [VLANE_NUM-1:0]    op_b_o
);

   typedef lane_word_u [VLANE_NUM-1:0] lane_vec_t;

   localparam int HALF_GRP = VLANE_NUM / 2;  // 16 bit ALUs per byte slot
   localparam int WORD_GRP = VLANE_NUM / 4;  // 32 bit ALUs per byte slot

   //////////////////////////////////////////////////////////////////////
   // Byte regrouping

   // Regroup one source vector so ALU k sees a whole element
   function automatic lane_vec_t gather(input lane_vec_t vs, input logic [SEW_W-1:0] sew);
      lane_vec_t res;
      int        b;
      int        g;
      for (int k = 0; k < VLANE_NUM; k++)
      begin
         if (sew >= SEW_32)
         begin
            b = k / WORD_GRP;
            g = k % WORD_GRP;
            res[k].word = {vs[4*g+3].bytes[b], vs[4*g+2].bytes[b],
                           vs[4*g+1].bytes[b], vs[4*g].bytes[b]};
         end
         else if (sew == SEW_16)
         begin
            b = k / HALF_GRP;
            g = k % HALF_GRP;
            res[k].word = {16'b0, vs[2*g+1].bytes[b], vs[2*g].bytes[b]};
         end
         else
            res[k] = vs[k];  // Byte 0 only, ALU ignores the rest
      end
      return res;
   endfunction

   lane_vec_t          op_a_next;
   lane_vec_t          vec_b;
   lane_vec_t          op_b_next;
   logic [WORD_W-1:0]  imm_sext;
   logic [WORD_W-1:0]  elem_mask;

   //////////////////////////////////////////////////////////////////////
   // Operand selection

   always_comb
   begin
      op_a_next = gather(vs1_i, sew_i);
      vec_b     = gather(vs2_i, sew_i);
      elem_mask = sew_mask(sew_i);
      imm_sext  = {{(WORD_W-IMM_W){imm_i[IMM_W-1]}}, imm_i};

      for (int k = 0; k < VLANE_NUM; k++)
      begin
         case (op2_sel_i)
            OP2_SCALAR: op_b_next[k].word = scalar_i & elem_mask;  // Cut to element
            OP2_IMM:    op_b_next[k].word = imm_sext & elem_mask;
            default:    op_b_next[k] = vec_b[k];
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stage 1 register

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         op_valid_o  <= 1'b0;
         op_sew_o    <= '0;
         op_opmode_o <= '0;
         op_a_o      <= '0;
         op_b_o      <= '0;
      end
      else
      begin
         op_valid_o  <= valid_i;
         op_sew_o    <= sew_i;
         op_opmode_o <= opmode_i;
         op_a_o      <= op_a_next;
         op_b_o      <= op_b_next;
      end
   end

endmodule

//--- verilog/lane_alu.sv
`timescale 1ns/1ps

module lane_alu
   import lane_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 valid_i,
   input  logic [SEW_W-1:0]     sew_i,
   input  logic [OPMODE_W-1:0]  opmode_i,
   input  lane_word_u           op_a_i,
   input  lane_word_u           op_b_i,
   output logic                 res_valid_o,
   output logic [SEW_W-1:0]     res_sew_o,
   output lane_word_u           res_o
);

   lane_word_u         elem_a;
   lane_word_u         elem_b;
   logic [WORD_W-1:0]  raw;
   lane_word_u         res_next;

   // Pick the element view, zero everything else
   always_comb
   begin
      elem_a = '0;
      elem_b = '0;
      if (sew_i >= SEW_32)
      begin
         elem_a = op_a_i;
         elem_b = op_b_i;
      end
      else if (sew_i == SEW_16)
      begin
         elem_a.half[0] = op_a_i.half[0];
         elem_b.half[0] = op_b_i.half[0];
      end
      else
      begin
         elem_a.bytes[0] = op_a_i.bytes[0];
         elem_b.bytes[0] = op_b_i.bytes[0];
      end
   end

   always_comb
   begin
      case (opmode_i)
         OP_ADD:  raw = elem_a.word + elem_b.word;
         OP_SUB:  raw = elem_a.word - elem_b.word;  // Borrow lands above element
         OP_AND:  raw = elem_a.word & elem_b.word;
         OP_OR:   raw = elem_a.word | elem_b.word;
         OP_XOR:  raw = elem_a.word ^ elem_b.word;
         default: raw = '0;
      endcase
      // Wrap at element width
      res_next.word = raw & sew_mask(sew_i);
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         res_valid_o <= 1'b0;
         res_sew_o   <= '0;
         res_o       <= '0;
      end
      else
      begin
         res_valid_o <= valid_i;
         res_sew_o   <= sew_i;
         res_o       <= res_next;
      end
   end

endmodule

//--- verilog/result_scatter.sv
`timescale 1ns/1ps

module result_scatter
   import lane_pkg::*;
#(
   parameter int VLANE_NUM = 8
)
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          valid_i,
   input  logic [SEW_W-1:0]              sew_i,
   input  lane_word_u [VLANE_NUM-1:0]    res_i,
   output logic                          valid_o,
   output lane_word_u [VLANE_NUM-1:0]    result_o
);

   // All result bytes in ALU order
   logic [4*VLANE_NUM-1:0][7:0]  all_bytes;
   // Low two bytes of each result, for 16 bit elements
   logic [2*VLANE_NUM-1:0][7:0]  low_bytes;

   lane_word_u [VLANE_NUM-1:0]   lay_8;
   lane_word_u [VLANE_NUM-1:0]   lay_16;
   lane_word_u [VLANE_NUM-1:0]   lay_32;
   lane_word_u [VLANE_NUM-1:0]   result_next;

   //////////////////////////////////////////////////////////////////////
   // Byte line-up

   always_comb
   begin
      for (int j = 0; j < VLANE_NUM; j++)
      begin
         for (int i = 0; i < 4; i++)
            all_bytes[j*4+i] = res_i[j].bytes[i];
         for (int i = 0; i < 2; i++)
            low_bytes[j*2+i] = res_i[j].bytes[i];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Layouts back to source lanes

   always_comb
   begin
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         // Lane l collects bytes l, l+N, l+2N, l+3N
         for (int b = 0; b < 4; b++)
            lay_32[l].bytes[b] = all_bytes[l + VLANE_NUM*b];

         lay_16[l].half[0] = {low_bytes[l + VLANE_NUM], low_bytes[l]};
         lay_16[l].half[1] = lay_16[l].half[0];  // Upper half mirrors

         lay_8[l].word = {4{res_i[l].bytes[0]}};
      end
   end

   always_comb
   begin
      if (sew_i >= SEW_32)
         result_next = lay_32;
      else if (sew_i == SEW_16)
         result_next = lay_16;
      else
         result_next = lay_8;
   end

   //////////////////////////////////////////////////////////////////////
   // Output register

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         valid_o  <= 1'b0;
         result_o <= '0;
      end
      else
      begin
         valid_o  <= valid_i;
         result_o <= result_next;
      end
   end

endmodule

//--- verilog/lane_cluster.sv
`timescale 1ns/1ps

module lane_cluster
   import lane_pkg::*;
#(
   parameter int VLANE_NUM = 8  // Multiple of 4
)
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          valid_i,
   input  logic [SEW_W-1:0]              sew_i,
   input  logic [OPMODE_W-1:0]           opmode_i,
   input  logic [OP2_SEL_W-1:0]          op2_sel_i,
   input  logic [WORD_W-1:0]             scalar_i,
   input  logic [IMM_W-1:0]              imm_i,
   input  lane_word_u [VLANE_NUM-1:0]    vs1_i,
   input  lane_word_u [VLANE_NUM-1:0]    vs2_i,
   output logic                          valid_o,
   output lane_word_u [VLANE_NUM-1:0]    result_o
);

   // Gather to ALU
   logic                          op_valid;
   logic [SEW_W-1:0]              op_sew;
   logic [OPMODE_W-1:0]           op_opmode;
   lane_word_u [VLANE_NUM-1:0]    op_a;
   lane_word_u [VLANE_NUM-1:0]    op_b;

   // ALU to scatter, only lane 0 control goes on
   logic [VLANE_NUM-1:0]              alu_valid;
   logic [VLANE_NUM-1:0][SEW_W-1:0]   alu_sew;
   lane_word_u [VLANE_NUM-1:0]        alu_res;

   operand_gather #(
      .VLANE_NUM(VLANE_NUM)
   )
   operand_gather_inst
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .valid_i(valid_i),
      .sew_i(sew_i),
      .opmode_i(opmode_i),
      .op2_sel_i(op2_sel_i),
      .scalar_i(scalar_i),
      .imm_i(imm_i),
      .vs1_i(vs1_i),
      .vs2_i(vs2_i),
      .op_valid_o(op_valid),
      .op_sew_o(op_sew),
      .op_opmode_o(op_opmode),
      .op_a_o(op_a),
      .op_b_o(op_b)
   );

   for (genvar k = 0; k < VLANE_NUM; k++)
   begin : g_alu
      lane_alu lane_alu_inst
      (
         .clk_i(clk_i),
         .rst_i(rst_i),
         .valid_i(op_valid),
         .sew_i(op_sew),
         .opmode_i(op_opmode),
         .op_a_i(op_a[k]),
         .op_b_i(op_b[k]),
         .res_valid_o(alu_valid[k]),
         .res_sew_o(alu_sew[k]),
         .res_o(alu_res[k])
      );
   end

   result_scatter #(
      .VLANE_NUM(VLANE_NUM)
   )
   result_scatter_inst
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .valid_i(alu_valid[0]),
      .sew_i(alu_sew[0]),
      .res_i(alu_res),
      .valid_o(valid_o),
      .result_o(result_o)
   );

endmodule

//--- verif/lane_cluster_model.svh
`ifndef LANE_CLUSTER_MODEL_SVH
`define LANE_CLUSTER_MODEL_SVH

// Reference model of the lane cluster, one 32 bit word per lane.
// NLANES comes from the including module.

typedef logic [NLANES-1:0][WORD_W-1:0] lanes_t;

// Bytes per element, code 3 counts as 32 bit
function automatic int elem_bytes(input logic [SEW_W-1:0] sew);
   if (sew == SEW_8)
      return 1;
   else if (sew == SEW_16)
      return 2;
   else
      return 4;
endfunction

// Keep only the element bytes
function automatic logic [31:0] trunc_elem(input logic [31:0] value, input int nbytes);
   logic [31:0] res;
   res = '0;
   for (int i = 0; i < nbytes; i++)
      res[8*i +: 8] = value[8*i +: 8];
   return res;
endfunction

// Element seen by ALU k; one formula for all widths
function automatic logic [31:0] gather_elem(input lanes_t vs, input logic [SEW_W-1:0] sew,
                                            input int k);
   logic [31:0] elem;
   int          nb;
   int          grp;
   int          slot;
   int          base;
   nb   = elem_bytes(sew);
   grp  = NLANES / nb;      // ALUs sharing one byte slot
   slot = k / grp;
   base = nb * (k % grp);   // First source lane of the element
   elem = '0;
   for (int i = 0; i < nb; i++)
      elem[8*i +: 8] = vs[base + i][8*slot +: 8];
   return elem;
endfunction

function automatic logic [31:0] op2_elem(input lanes_t vs2, input logic [OP2_SEL_W-1:0] sel,
                                         input logic [31:0] scalar, input logic [IMM_W-1:0] imm,
                                         input logic [SEW_W-1:0] sew, input int k);
   logic [31:0] val;
   case (sel)
      OP2_SCALAR: val = scalar;
      OP2_IMM:    val = {{(32-IMM_W){imm[IMM_W-1]}}, imm};  // Sign extend
      default:    val = gather_elem(vs2, sew, k);
   endcase
   return trunc_elem(val, elem_bytes(sew));
endfunction

function automatic logic [31:0] alu_elem(input logic [31:0] a, input logic [31:0] b,
                                         input logic [OPMODE_W-1:0] op,
                                         input logic [SEW_W-1:0] sew);
   logic [31:0] r;
   case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      default: r = '0;
   endcase
   return trunc_elem(r, elem_bytes(sew));
endfunction

// Whole beat: gather, ALU, scatter back into source lane layout
function automatic lanes_t expected_result(input lanes_t vs1, input lanes_t vs2,
                                           input logic [SEW_W-1:0] sew,
                                           input logic [OPMODE_W-1:0] op,
                                           input logic [OP2_SEL_W-1:0] sel,
                                           input logic [31:0] scalar,
                                           input logic [IMM_W-1:0] imm);
   lanes_t alu_res;
   lanes_t out;
   int     nb;
   int     idx;
   nb = elem_bytes(sew);
   for (int k = 0; k < NLANES; k++)
      alu_res[k] = alu_elem(gather_elem(vs1, sew, k),
                            op2_elem(vs2, sel, scalar, imm, sew, k), op, sew);
   for (int l = 0; l < NLANES; l++)
   begin
      // Bytes above the element repeat the element pattern
      for (int b = 0; b < 4; b++)
      begin
         idx = l + NLANES * (b % nb);
         out[l][8*b +: 8] = alu_res[idx / nb][8*(idx % nb) +: 8];
      end
   end
   return out;
endfunction

`endif

//--- verif/lane_cluster_tb.sv
`timescale 1ns/1ps

module lane_cluster_tb
   import lane_pkg::*;
();

   localparam int NLANES       = 8;
   localparam int PHASE_CYCLES = 250;  // Cycles per stimulus phase
   localparam int NUM_PHASES   = 4;
   localparam int NUM_CYCLES   = PHASE_CYCLES * NUM_PHASES;
   localparam int WATCHDOG_NS  = (NUM_CYCLES + 20) * 10 * 2;

   `include "lane_cluster_model.svh"

   logic                         clk_i = 1'b0;
   logic                         rst_i;
   logic                         valid_i;
   logic [SEW_W-1:0]             sew_i;
   logic [OPMODE_W-1:0]          opmode_i;
   logic [OP2_SEL_W-1:0]         op2_sel_i;
   logic [WORD_W-1:0]            scalar_i;
   logic [IMM_W-1:0]             imm_i;
   lane_word_u [NLANES-1:0]      vs1_i;
   lane_word_u [NLANES-1:0]      vs2_i;
   logic                         valid_o;
   lane_word_u [NLANES-1:0]      result_o;

   integer  seed = 77884;
   lanes_t  exp_q[$];            // Expected beats in order
   logic [2:0] vpipe = 3'b000;   // Expected valid per pipeline stage

   lane_cluster #(
      .VLANE_NUM(NLANES)
   )
   lane_cluster_inst
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .valid_i(valid_i),
      .sew_i(sew_i),
      .opmode_i(opmode_i),
      .op2_sel_i(op2_sel_i),
      .scalar_i(scalar_i),
      .imm_i(imm_i),
      .vs1_i(vs1_i),
      .vs2_i(vs2_i),
      .valid_o(valid_o),
      .result_o(result_o)
   );

   always #5 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("[ERROR] %s actual=0x%08h expected=0x%08h", name, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   // Phase picks SEW, valid density and opcode range of a random beat
   task automatic drive_beat(input int phase);
      logic [31:0] r;
      r = $random(seed);
      if (phase < 3)
         valid_i = (r % 32'd10) < 32'd7;
      else
         valid_i = (r % 32'd20) < 32'd19;  // Long back-to-back runs
      r = $random(seed);
      case (phase)
         0:       sew_i = SEW_8;
         1:       sew_i = SEW_16;
         2:       sew_i = SEW_32;
         default: sew_i = r[1:0];  // Code 3 included
      endcase
      r = $random(seed);
      if (phase < 3)
         r = r % 32'd5;
      opmode_i = r[2:0];
      r = $random(seed);
      r = r % 32'd3;  // Reserved select never driven
      op2_sel_i = r[1:0];
      scalar_i = $random(seed);
      r = $random(seed);
      imm_i = r[4:0];
      for (int l = 0; l < NLANES; l++)
      begin
         vs1_i[l].word = $random(seed);
         vs2_i[l].word = $random(seed);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Beat capture and output checking

   always @(posedge clk_i)
   begin
      if (!rst_i)
         vpipe <= 3'b000;
      else
      begin
         vpipe <= {vpipe[1:0], valid_i};
         if (valid_i)
            exp_q.push_back(expected_result(vs1_i, vs2_i, sew_i, opmode_i, op2_sel_i,
                                            scalar_i, imm_i));
      end
   end

   // Outputs are stable half a cycle after the edge
   always @(negedge clk_i)
   begin : check_out
      lanes_t exp_lanes;
      if (valid_o === 1'b1 && exp_q.size() == 0)
      begin
         $display("valid_o went high with no beat outstanding");
         $display("CHECKS FAILED");
         $fatal(1);
      end
      else
      begin
         check_value("valid_o", {31'b0, valid_o}, {31'b0, vpipe[2]});
         if (valid_o)
         begin
            exp_lanes = exp_q.pop_front();
            for (int l = 0; l < NLANES; l++)
               check_value($sformatf("result_o[%0d]", l), result_o[l].word, exp_lanes[l]);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Main sequence

   initial
   begin
      rst_i     = 1'b0;
      valid_i   = 1'b0;
      sew_i     = SEW_8;
      opmode_i  = OP_ADD;
      op2_sel_i = OP2_VEC;
      scalar_i  = '0;
      imm_i     = '0;
      vs1_i     = '0;
      vs2_i     = '0;

      repeat (4) @(posedge clk_i);
      #1 rst_i = 1'b1;

      for (int phase = 0; phase < NUM_PHASES; phase++)
      begin
         for (int c = 0; c < PHASE_CYCLES; c++)
         begin
            @(posedge clk_i);
            #1;
            drive_beat(phase);
         end
      end

      @(posedge clk_i);
      #1 valid_i = 1'b0;
      repeat (6) @(posedge clk_i);  // Drain the 3 stage pipe
      #2;

      if (exp_q.size() != 0)
      begin
         $display("%0d beats never came out of the DUT", exp_q.size());
         $display("CHECKS FAILED");
         $fatal(1);
      end
      else
      begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, the run did not finish in time");
      $display("CHECKS FAILED");
      $fatal(1);
   end

endmodule

//--- tb.f
+incdir+verif
verilog/lane_pkg.sv
verilog/operand_gather.sv
verilog/lane_alu.sv
verilog/result_scatter.sv
verilog/lane_cluster.sv
verif/lane_cluster_tb.sv

//--- Makefile
# Verilator build and run of the lane cluster testbench

OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing -f tb.f --top-module lane_cluster_tb \
		-Mdir $(OBJ_DIR) -o lane_cluster_sim
	./$(OBJ_DIR)/lane_cluster_sim

clean:
	rm -rf $(OBJ_DIR)
